// ==== hw/sat_pkg.sv ====
package sat_pkg;

    // literal code of one variable inside a clause word
    typedef enum logic [1:0] {
        LIT_NONE = 2'b00,
        LIT_POS  = 2'b01,
        LIT_NEG  = 2'b10
    } lit_e;

    // current assignment of one variable
    typedef enum logic [1:0] {
        VAL_FREE  = 2'b00,
        VAL_TRUE  = 2'b01,
        VAL_FALSE = 2'b10
    } val_e;

    // operations ordered from the variable state list
    typedef enum logic [2:0] {
        OP_NONE,
        OP_CLEAR,
        OP_IMPLY,
        OP_DECIDE,
        OP_BKT
    } var_op_e;

    // search FSM states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_IMPLY,
        ST_DECIDE,
        ST_BKT,
        ST_DONE
    } ctrl_state_e;

endpackage

// ==== hw/clause_array.sv ====
`timescale 1ns/1ps

module clause_array #(
    parameter int NUM_VARS    = 8,
    parameter int NUM_CLAUSES = 8
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                load_i,
    input  logic [$clog2(NUM_CLAUSES)-1:0]      load_idx_i,
    input  logic [2*NUM_VARS-1:0]               clause_i,
    input  logic                                busy_i,
    input  sat_pkg::val_e [NUM_VARS-1:0]        var_val_i,
    output logic                                all_sat_o,
    output logic                                conflict_o,
    output logic                                unit_o,
    output logic [$clog2(NUM_VARS)-1:0]         imp_var_o,
    output sat_pkg::val_e                       imp_val_o
);
    import sat_pkg::*;

    localparam int VAR_W = $clog2(NUM_VARS);
    localparam int CNT_W = $clog2(NUM_VARS + 1);

    logic [2*NUM_VARS-1:0] clause_q [NUM_CLAUSES];
    logic [NUM_CLAUSES-1:0] valid_q;
    logic                   load_valid;
    logic [NUM_CLAUSES-1:0] c_sat;
    logic [NUM_CLAUSES-1:0] c_conf;
    logic [NUM_CLAUSES-1:0] c_unit;
    logic [VAR_W-1:0]       u_var [NUM_CLAUSES];
    val_e                   u_val [NUM_CLAUSES];

    // a slot holds a clause once any literal is present
    always_comb begin
        load_valid = 1'b0;
        for (int v = 0; v < NUM_VARS; v++) begin
            if (clause_i[2*v +: 2] == LIT_POS || clause_i[2*v +: 2] == LIT_NEG) begin
                load_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_i && !busy_i) begin
            clause_q[load_idx_i] <= clause_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (load_i && !busy_i) begin
            valid_q[load_idx_i] <= load_valid;
        end
    end

    for (genvar c = 0; c < NUM_CLAUSES; c++) begin : g_eval
        logic [NUM_VARS-1:0] pos;
        logic [NUM_VARS-1:0] neg;
        logic [CNT_W-1:0]    n_true;
        logic [CNT_W-1:0]    n_free;

        for (genvar v = 0; v < NUM_VARS; v++) begin : g_lit
            assign pos[v] = clause_q[c][2*v +: 2] == LIT_POS;
            assign neg[v] = clause_q[c][2*v +: 2] == LIT_NEG;
        end

        // last free literal seen is the implied one when the clause is unit
        always_comb begin
            n_true   = '0;
            n_free   = '0;
            u_var[c] = '0;
            u_val[c] = VAL_FREE;
            for (int v = 0; v < NUM_VARS; v++) begin
                if (pos[v] || neg[v]) begin
                    if (var_val_i[v] == VAL_FREE) begin
                        n_free   = n_free + 1'b1;
                        u_var[c] = VAR_W'(v);
                        u_val[c] = pos[v] ? VAL_TRUE : VAL_FALSE;
                    end else if (pos[v] == (var_val_i[v] == VAL_TRUE)) begin
                        n_true = n_true + 1'b1;
                    end
                end
            end
        end

        assign c_sat[c]  = n_true != '0;
        assign c_conf[c] = valid_q[c] && n_true == '0 && n_free == '0;
        assign c_unit[c] = valid_q[c] && n_true == '0 && n_free == CNT_W'(1);
    end

    assign all_sat_o  = &(c_sat | ~valid_q);
    assign conflict_o = |c_conf;
    assign unit_o     = |c_unit;

    // lowest unit clause wins
    always_comb begin
        imp_var_o = '0;
        imp_val_o = VAL_FREE;
        for (int c = NUM_CLAUSES - 1; c >= 0; c--) begin
            if (c_unit[c]) begin
                imp_var_o = u_var[c];
                imp_val_o = u_val[c];
            end
        end
    end

endmodule

// ==== hw/var_state_list.sv ====
`timescale 1ns/1ps

module var_state_list #(
    parameter int NUM_VARS = 8,
    parameter int LVL_W    = 4
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  sat_pkg::var_op_e                op_i,
    input  logic [$clog2(NUM_VARS)-1:0]     imp_var_i,
    input  sat_pkg::val_e                   imp_val_i,
    output sat_pkg::val_e [NUM_VARS-1:0]    var_val_o,
    output logic [LVL_W-1:0]                cur_lvl_o,
    output logic                            bkt_done_o,
    output logic                            bkt_empty_o
);
    import sat_pkg::*;

    localparam int VAR_W = $clog2(NUM_VARS);

    val_e [NUM_VARS-1:0] val_q;
    logic [LVL_W-1:0]    lvl_q [NUM_VARS];
    logic [NUM_VARS-1:0] dec_q;
    logic [NUM_VARS-1:0] flip_q;
    logic [LVL_W-1:0]    cur_lvl_q;
    logic                free_found;
    logic [VAR_W-1:0]    free_idx;
    logic                dec_found;
    logic [VAR_W-1:0]    dec_idx;
    logic                flip_now;

    // lowest free variable and the decision owning the current level
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        dec_found  = 1'b0;
        dec_idx    = '0;
        for (int v = NUM_VARS - 1; v >= 0; v--) begin
            if (val_q[v] == VAL_FREE) begin
                free_found = 1'b1;
                free_idx   = VAR_W'(v);
            end
            if (val_q[v] != VAL_FREE && dec_q[v] && lvl_q[v] == cur_lvl_q) begin
                dec_found = 1'b1;
                dec_idx   = VAR_W'(v);
            end
        end
    end

    assign flip_now    = dec_found && !flip_q[dec_idx];
    assign bkt_done_o  = (op_i == OP_BKT) && (cur_lvl_q != '0) && flip_now;
    assign bkt_empty_o = (op_i == OP_BKT) && (cur_lvl_q == '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int v = 0; v < NUM_VARS; v++) begin
                val_q[v] <= VAL_FREE;
            end
            dec_q     <= '0;
            flip_q    <= '0;
            cur_lvl_q <= '0;
        end else begin
            case (op_i)
                OP_CLEAR: begin
                    for (int v = 0; v < NUM_VARS; v++) begin
                        val_q[v] <= VAL_FREE;
                    end
                    dec_q     <= '0;
                    flip_q    <= '0;
                    cur_lvl_q <= '0;
                end
                OP_IMPLY: begin
                    val_q[imp_var_i]  <= imp_val_i;
                    dec_q[imp_var_i]  <= 1'b0;
                    flip_q[imp_var_i] <= 1'b0;
                end
                OP_DECIDE: begin
                    if (free_found) begin
                        val_q[free_idx]  <= VAL_TRUE;
                        dec_q[free_idx]  <= 1'b1;
                        flip_q[free_idx] <= 1'b0;
                        cur_lvl_q        <= cur_lvl_q + 1'b1;
                    end
                end
                OP_BKT: begin
                    if (cur_lvl_q != '0) begin
                        // undo the whole level first
                        for (int v = 0; v < NUM_VARS; v++) begin
                            if (val_q[v] != VAL_FREE && lvl_q[v] == cur_lvl_q) begin
                                val_q[v]  <= VAL_FREE;
                                dec_q[v]  <= 1'b0;
                                flip_q[v] <= 1'b0;
                            end
                        end
                        // then keep the decision, now false
                        if (flip_now) begin
                            val_q[dec_idx]  <= VAL_FALSE;
                            dec_q[dec_idx]  <= 1'b1;
                            flip_q[dec_idx] <= 1'b1;
                        end else begin
                            cur_lvl_q <= cur_lvl_q - 1'b1;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (op_i == OP_IMPLY) begin
            lvl_q[imp_var_i] <= cur_lvl_q;
        end else if (op_i == OP_DECIDE && free_found) begin
            lvl_q[free_idx] <= cur_lvl_q + 1'b1;
        end
    end

    assign var_val_o = val_q;
    assign cur_lvl_o = cur_lvl_q;

endmodule

// ==== hw/ctrl_core.sv ====
`timescale 1ns/1ps

module ctrl_core (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             start_i,
    input  logic             all_sat_i,
    input  logic             conflict_i,
    input  logic             unit_i,
    input  logic             bkt_done_i,
    input  logic             bkt_empty_i,
    output sat_pkg::var_op_e op_o,
    output logic             busy_o,
    output logic             fin_o,
    output logic             fin_sat_o
);
    import sat_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        sat_q;

    always_comb begin
        state_d = state_q;
        op_o    = OP_NONE;
        fin_o   = 1'b0;
        case (state_q)
            ST_IDLE: begin
                // clear on the sampling edge so cycle 1 sees free variables
                if (start_i) begin
                    op_o    = OP_CLEAR;
                    state_d = ST_IMPLY;
                end
            end
            ST_IMPLY: begin
                if (conflict_i) begin
                    state_d = ST_BKT;
                end else if (unit_i) begin
                    op_o = OP_IMPLY;
                end else if (all_sat_i) begin
                    state_d = ST_DONE;
                end else begin
                    state_d = ST_DECIDE;
                end
            end
            ST_DECIDE: begin
                op_o    = OP_DECIDE;
                state_d = ST_IMPLY;
            end
            ST_BKT: begin
                op_o = OP_BKT;
                if (bkt_empty_i) begin
                    state_d = ST_DONE;
                end else if (bkt_done_i) begin
                    state_d = ST_IMPLY;
                end
            end
            ST_DONE: begin
                fin_o   = 1'b1;
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            sat_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            // finishing out of propagation means every clause holds
            if (state_d == ST_DONE && state_q != ST_DONE) begin
                sat_q <= state_q == ST_IMPLY;
            end
        end
    end

    assign busy_o    = state_q != ST_IDLE;
    assign fin_sat_o = sat_q;

endmodule

// ==== hw/result_out.sv ====
`timescale 1ns/1ps

module result_out #(
    parameter int NUM_VARS = 8
) (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         start_i,
    input  logic                         busy_i,
    input  logic                         fin_i,
    input  logic                         fin_sat_i,
    input  sat_pkg::val_e [NUM_VARS-1:0] var_val_i,
    output logic                         done_o,
    output logic                         sat_o,
    output logic                         unsat_o,
    output logic [NUM_VARS-1:0]          model_o
);
    import sat_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            done_o  <= 1'b0;
            sat_o   <= 1'b0;
            unsat_o <= 1'b0;
        end else begin
            done_o <= fin_i;
            if (start_i && !busy_i) begin
                sat_o   <= 1'b0;
                unsat_o <= 1'b0;
            end else if (fin_i) begin
                sat_o   <= fin_sat_i;
                unsat_o <= !fin_sat_i;
            end
        end
    end

    // free variables read as false
    always_ff @(posedge clk) begin
        if (fin_i) begin
            for (int v = 0; v < NUM_VARS; v++) begin
                model_o[v] <= var_val_i[v] == VAL_TRUE;
            end
        end
    end

endmodule

// ==== hw/sat_core.sv ====
`timescale 1ns/1ps

module sat_core #(
    parameter int NUM_VARS    = 8,
    parameter int NUM_CLAUSES = 8,
    parameter int LVL_W       = 4
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           load_i,
    input  logic [$clog2(NUM_CLAUSES)-1:0] load_idx_i,
    input  logic [2*NUM_VARS-1:0]          clause_i,
    input  logic                           start_i,
    output logic                           busy_o,
    output logic                           done_o,
    output logic                           sat_o,
    output logic                           unsat_o,
    output logic [NUM_VARS-1:0]            model_o
);
    import sat_pkg::*;

    logic                        all_sat;
    logic                        conflict;
    logic                        unit;
    logic [$clog2(NUM_VARS)-1:0] imp_var;
    val_e                        imp_val;
    val_e [NUM_VARS-1:0]         var_val;
    var_op_e                     op;
    logic                        bkt_done;
    logic                        bkt_empty;
    logic                        fin;
    logic                        fin_sat;

    clause_array #(
        .NUM_VARS    (NUM_VARS),
        .NUM_CLAUSES (NUM_CLAUSES)
    ) i_clause_array (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .load_i     (load_i),
        .load_idx_i (load_idx_i),
        .clause_i   (clause_i),
        .busy_i     (busy_o),
        .var_val_i  (var_val),
        .all_sat_o  (all_sat),
        .conflict_o (conflict),
        .unit_o     (unit),
        .imp_var_o  (imp_var),
        .imp_val_o  (imp_val)
    );

    // level is kept internal to the backtrack logic
    var_state_list #(
        .NUM_VARS (NUM_VARS),
        .LVL_W    (LVL_W)
    ) i_var_state_list (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .op_i        (op),
        .imp_var_i   (imp_var),
        .imp_val_i   (imp_val),
        .var_val_o   (var_val),
        .cur_lvl_o   (),
        .bkt_done_o  (bkt_done),
        .bkt_empty_o (bkt_empty)
    );

    ctrl_core i_ctrl_core (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .start_i     (start_i),
        .all_sat_i   (all_sat),
        .conflict_i  (conflict),
        .unit_i      (unit),
        .bkt_done_i  (bkt_done),
        .bkt_empty_i (bkt_empty),
        .op_o        (op),
        .busy_o      (busy_o),
        .fin_o       (fin),
        .fin_sat_o   (fin_sat)
    );

    result_out #(
        .NUM_VARS (NUM_VARS)
    ) i_result_out (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .start_i   (start_i),
        .busy_i    (busy_o),
        .fin_i     (fin),
        .fin_sat_i (fin_sat),
        .var_val_i (var_val),
        .done_o    (done_o),
        .sat_o     (sat_o),
        .unsat_o   (unsat_o),
        .model_o   (model_o)
    );

endmodule

// ==== sim/tb_sat_core.sv ====
`timescale 1ns/1ps

module tb_sat_core;
    import sat_pkg::*;

    localparam int NUM_VARS      = 8;
    localparam int NUM_CLAUSES   = 8;
    localparam int LVL_W         = 4;
    localparam int IDX_W         = $clog2(NUM_CLAUSES);
    localparam int NUM_RANDOM    = 24;
    localparam int MAX_FILE_INST = 8;
    localparam int MAX_LATENCY   = 4 * NUM_VARS * (2 ** NUM_VARS);
    localparam int RUN_CYCLES    = MAX_LATENCY + NUM_CLAUSES + 8;
    localparam int CYCLE_LIMIT   = (MAX_FILE_INST + NUM_RANDOM + 4) * RUN_CYCLES + 16;

    logic                  clk;
    logic                  rst_n_i;
    logic                  load_i;
    logic [IDX_W-1:0]      load_idx_i;
    logic [2*NUM_VARS-1:0] clause_i;
    logic                  start_i;
    logic                  busy_o;
    logic                  done_o;
    logic                  sat_o;
    logic                  unsat_o;
    logic [NUM_VARS-1:0]   model_o;

    // clause set currently loaded in the DUT
    logic [2*NUM_VARS-1:0] cls [NUM_CLAUSES];
    int                    ncls;
    logic [31:0]           rng_state;
    int                    cycle_count;

    sat_core #(
        .NUM_VARS    (NUM_VARS),
        .NUM_CLAUSES (NUM_CLAUSES),
        .LVL_W       (LVL_W)
    ) i_sat_core (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .load_i     (load_i),
        .load_idx_i (load_idx_i),
        .clause_i   (clause_i),
        .start_i    (start_i),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .sat_o      (sat_o),
        .unsat_o    (unsat_o),
        .model_o    (model_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("Error at %0t: %s is %0h, expected %0h",
                                     $time, name, actual, expected));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bit clause_true(input logic [2*NUM_VARS-1:0] c,
                                       input logic [NUM_VARS-1:0] model);
        for (int v = 0; v < NUM_VARS; v++) begin
            if (c[2*v +: 2] == LIT_POS && model[v]) begin
                return 1'b1;
            end
            if (c[2*v +: 2] == LIT_NEG && !model[v]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // empty words are not clauses
    function automatic bit formula_true(input logic [NUM_VARS-1:0] model);
        for (int c = 0; c < ncls; c++) begin
            if (cls[c] != '0 && !clause_true(cls[c], model)) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic bit brute_force_sat();
        for (int a = 0; a < 2 ** NUM_VARS; a++) begin
            if (formula_true(NUM_VARS'(a))) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic read_value(input int fd, output logic [31:0] val, output bit ok);
        string line;
        int    code;
        val = '0;
        ok  = 1'b0;
        while (!ok && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line[0] != "#" && $sscanf(line, "%h", val) == 1) begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic load_set();
        for (int i = 0; i < NUM_CLAUSES; i++) begin
            load_i     = 1'b1;
            load_idx_i = IDX_W'(i);
            clause_i   = (i < ncls) ? cls[i] : '0;
            @(negedge clk);
        end
        load_i = 1'b0;
    endtask

    task automatic build_random();
        int n;
        int vmax;
        int picked;
        int v;
        rng_state = lcg_next(rng_state);
        n = 4 + int'(rng_state[23:16]) % 5;
        rng_state = lcg_next(rng_state);
        // few variables make unsat sets likely
        vmax = 3 + int'(rng_state[23:16]) % 6;
        for (int c = 0; c < n; c++) begin
            cls[c] = '0;
            picked = 0;
            while (picked < 3) begin
                rng_state = lcg_next(rng_state);
                v = int'(rng_state[23:16]) % vmax;
                if (cls[c][2*v +: 2] == LIT_NONE) begin
                    cls[c][2*v +: 2] = rng_state[24] ? LIT_NEG : LIT_POS;
                    picked++;
                end
            end
        end
        ncls = n;
    endtask

    task automatic run_solver(input bit poke, input int poke_idx);
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        check_value("busy_o", busy_o, 1);
        check_value("done_o", done_o, 0);
        if (poke) begin
            // both strobes stay up for every busy cycle of the search
            load_i     = 1'b1;
            load_idx_i = IDX_W'(poke_idx);
            clause_i   = '0;
            start_i    = 1'b1;
        end
        while (done_o !== 1'b1) begin
            check_value("busy_o", busy_o, 1);
            @(negedge clk);
        end
        load_i  = 1'b0;
        start_i = 1'b0;
        check_value("busy_o", busy_o, 0);
        @(negedge clk);
        check_value("done_o", done_o, 0);
    endtask

    task automatic check_result(input bit expected_sat);
        check_value("sat_o ^ unsat_o", sat_o ^ unsat_o, 1);
        check_value("sat_o", sat_o, expected_sat);
        if (sat_o) begin
            check_value("clauses true under model_o", formula_true(model_o), 1);
        end
    endtask

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= CYCLE_LIMIT) begin
                report_failure($sformatf("timeout: run still going after %0d cycles",
                                         cycle_count));
            end
        end
    end

    initial begin
        int          fd;
        int          file_count;
        bit          ok;
        bit          ok_word;
        logic [31:0] count;
        logic [31:0] word;
        logic [31:0] verdict;
        rst_n_i    = 1'b0;
        load_i     = 1'b0;
        load_idx_i = '0;
        clause_i   = '0;
        start_i    = 1'b0;
        rng_state  = 32'hcecc;
        ncls       = 0;
        file_count = 0;
        repeat (4) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        check_value("busy_o", busy_o, 0);
        check_value("done_o", done_o, 0);
        check_value("sat_o", sat_o, 0);
        check_value("unsat_o", unsat_o, 0);

        // all slots empty after reset
        run_solver(1'b0, 0);
        check_result(1'b1);

        fd = $fopen("sim/sat_core_input.txt", "r");
        if (fd == 0) begin
            report_failure("could not open sim/sat_core_input.txt");
        end
        read_value(fd, count, ok);
        while (ok) begin
            if (count > NUM_CLAUSES || file_count >= MAX_FILE_INST) begin
                report_failure("data file holds an instance that does not fit");
            end
            for (int i = 0; i < int'(count); i++) begin
                read_value(fd, word, ok_word);
                if (!ok_word) begin
                    report_failure("data file ends inside an instance");
                end
                cls[i] = word[2*NUM_VARS-1:0];
            end
            read_value(fd, verdict, ok_word);
            if (!ok_word) begin
                report_failure("data file ends before a verdict");
            end
            ncls = int'(count);
            load_set();
            run_solver(1'b0, 0);
            check_result(verdict[0]);
            file_count++;
            read_value(fd, count, ok);
        end
        $fclose(fd);
        if (file_count == 0) begin
            report_failure("no instances found in the data file");
        end

        for (int r = 0; r < NUM_RANDOM; r++) begin
            build_random();
            load_set();
            run_solver(1'b0, 0);
            check_result(brute_force_sat());
        end

        // x0 and not x0 with a load and a start held up while busy
        ncls   = 2;
        cls[0] = 16'h0001;
        cls[1] = 16'h0002;
        load_set();
        run_solver(1'b1, 1);
        check_result(brute_force_sat());
        run_solver(1'b0, 0);
        check_result(brute_force_sat());

        // empty the second slot while idle
        load_i     = 1'b1;
        load_idx_i = IDX_W'(1);
        clause_i   = '0;
        @(negedge clk);
        load_i = 1'b0;
        cls[1] = '0;
        run_solver(1'b0, 0);
        check_result(brute_force_sat());

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== sat_core.f ====
hw/sat_pkg.sv
hw/clause_array.sv
hw/var_state_list.sv
hw/ctrl_core.sv
hw/result_out.sv
hw/sat_core.sv
sim/tb_sat_core.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_sat_core -f sat_core.f -o tb_sat_core
out=$(./obj_dir/tb_sat_core || true)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== sim/sat_core_input.txt ====
# per instance: clause count, then one clause word per line, then verdict (1 sat, 0 unsat)
# clause word in hex: 2 bits per variable, var 0 in bits 1:0, 01 positive, 10 negative
# unit chain x0 -> x1 -> x2 -> not x3
4
0001
0006
0018
00a0
1
# x0 and not x0
2
0001
0002
0
# every sign combination over x0, x1, x2
8
0015
0025
0019
0029
0016
0026
001a
002a
0
# deciding x0 true fails, flipped to false
4
0006
000a
0050
4020
1
